// File: include/pipe_trace_cfg.svh
// pipe trace configuration
`ifndef PIPE_TRACE_CFG_SVH
`define PIPE_TRACE_CFG_SVH

//////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////

// tag width, one table entry per tag value
`define PT_TAG_W 4

// number of table entries
`define PT_TAG_DEPTH (1 << `PT_TAG_W)

// free running cycle counter, wraps
`define PT_CYCLE_W 16

// per-stage stall counters, saturate at all ones
`define PT_STALL_W 4

`endif

// File: src/pipe_trace_pkg.sv
// pipe trace types
`include "pipe_trace_cfg.svh"

package pipe_trace_pkg;

    // one pipeline stage: occupied flag and instruction tag
    typedef struct packed {
        logic                 valid;
        logic [`PT_TAG_W-1:0] tag;
    } stage_slot_t;

    // stage occupancy as seen by the table and record builder
    typedef struct packed {
        stage_slot_t            f;
        stage_slot_t            d;
        stage_slot_t            e;
        stage_slot_t            m;
        stage_slot_t            w;
        logic [`PT_CYCLE_W-1:0] cycle;
        // valid slot held in place by stall
        logic                   stall_f;
        logic                   stall_d;
    } stage_status_t;

    //////////////////////////////////////////////////
    // instruction word views
    //////////////////////////////////////////////////

    // R/I format, destination register in [11:7]
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // S format, store offset split across [31:25] and [11:7]
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r_view;
        s_view_t s_view;
    } instr_word_u;

    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // per-tag bookkeeping
    typedef struct packed {
        instr_word_u            word;
        logic [`PT_CYCLE_W-1:0] fetch_cycle;
        logic [`PT_STALL_W-1:0] fetch_stalls;
        logic [`PT_STALL_W-1:0] decode_stalls;
    } table_entry_t;

    typedef enum logic [1:0] {
        KIND_REG   = 2'd0,
        KIND_STORE = 2'd1,
        KIND_OTHER = 2'd2
    } trace_kind_e;

    // one record per retired instruction
    typedef struct packed {
        logic [`PT_TAG_W-1:0]   tag;
        trace_kind_e            kind;
        logic [11:0]            field;
        logic [`PT_CYCLE_W-1:0] fetch_cycle;
        logic [`PT_CYCLE_W-1:0] retire_cycle;
        logic [`PT_STALL_W-1:0] fetch_stalls;
        logic [`PT_STALL_W-1:0] decode_stalls;
        logic [31:0]            word;
    } trace_record_t;

endpackage

// File: src/stage_tracker.sv
// pipeline stage tracker
`timescale 1ns/10ps
`include "pipe_trace_cfg.svh"

module stage_tracker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  logic                          stall,
    input  logic                          flush,
    output pipe_trace_pkg::stage_status_t status,
    output pipe_trace_pkg::stage_slot_t   alloc
);

    pipe_trace_pkg::stage_slot_t f_slot;
    pipe_trace_pkg::stage_slot_t d_slot;
    pipe_trace_pkg::stage_slot_t e_slot;
    pipe_trace_pkg::stage_slot_t m_slot;
    pipe_trace_pkg::stage_slot_t w_slot;

    logic [`PT_TAG_W-1:0]   next_tag;
    logic [`PT_CYCLE_W-1:0] cycle;
    logic                   accept;

    // a fetch is taken only when the front end moves
    assign accept = fetch_valid & ~stall & ~flush;

    assign alloc.valid = accept;
    assign alloc.tag   = next_tag;

    //////////////////////////////////////////////////
    // stage occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            f_slot <= '0;
            d_slot <= '0;
            e_slot <= '0;
            m_slot <= '0;
            w_slot <= '0;
        end else begin
            // back end always drains
            m_slot <= e_slot;
            w_slot <= m_slot;
            if (flush) begin
                // flush beats stall, front end killed
                f_slot <= '0;
                d_slot <= '0;
                e_slot <= '0;
            end else if (stall) begin
                // f and d hold, bubble into execute
                e_slot <= '0;
            end else begin
                f_slot.valid <= fetch_valid;
                f_slot.tag   <= next_tag;
                d_slot       <= f_slot;
                e_slot       <= d_slot;
            end
        end
    end

    // tag counter and cycle counter
    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag <= '0;
            cycle    <= '0;
        end else begin
            cycle <= cycle + 1'b1;
            // sequential tags, wraps at table depth
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // status out
    //////////////////////////////////////////////////

    assign status.f       = f_slot;
    assign status.d       = d_slot;
    assign status.e       = e_slot;
    assign status.m       = m_slot;
    assign status.w       = w_slot;
    assign status.cycle   = cycle;
    // occupied slot that will hold this edge
    assign status.stall_f = stall & ~flush & f_slot.valid;
    assign status.stall_d = stall & ~flush & d_slot.valid;

endmodule

// File: src/trace_table.sv
// per-tag trace table
`timescale 1ns/10ps
`include "pipe_trace_cfg.svh"

module trace_table (
    input  logic                          clk,
    input  logic                          rst,
    input  pipe_trace_pkg::stage_slot_t   alloc,
    input  logic [31:0]                   fetch_word,
    input  pipe_trace_pkg::stage_status_t status,
    output pipe_trace_pkg::table_entry_t  rd_entry
);

    localparam int DEPTH = `PT_TAG_DEPTH;

    pipe_trace_pkg::table_entry_t entries [DEPTH];

    logic [`PT_STALL_W-1:0] f_stalls_cur;
    logic [`PT_STALL_W-1:0] d_stalls_cur;
    logic [`PT_STALL_W-1:0] f_stalls_nxt;
    logic [`PT_STALL_W-1:0] d_stalls_nxt;
    logic [`PT_CYCLE_W-1:0] f_cycle;

    //////////////////////////////////////////////////
    // stall counter update
    //////////////////////////////////////////////////

    // current counts of the instructions in f and d
    assign f_stalls_cur = entries[status.f.tag].fetch_stalls;
    assign d_stalls_cur = entries[status.d.tag].decode_stalls;

    // saturate at all ones so a long stall never wraps
    assign f_stalls_nxt = (&f_stalls_cur) ? f_stalls_cur : f_stalls_cur + 1'b1;
    assign d_stalls_nxt = (&d_stalls_cur) ? d_stalls_cur : d_stalls_cur + 1'b1;

    // new fetch sits in f during the next cycle
    assign f_cycle = status.cycle + 1'b1;

    //////////////////////////////////////////////////
    // writes
    //////////////////////////////////////////////////

    // f and d never share a tag and alloc never coincides with a stall,
    // so the three writes land on distinct entries
    always_ff @(posedge clk) begin
        if (!rst) begin
            if (alloc.valid) begin
                entries[alloc.tag].word          <= fetch_word;
                entries[alloc.tag].fetch_cycle   <= f_cycle;
                entries[alloc.tag].fetch_stalls  <= '0;
                entries[alloc.tag].decode_stalls <= '0;
            end
            if (status.stall_f) begin
                entries[status.f.tag].fetch_stalls <= f_stalls_nxt;
            end
            if (status.stall_d) begin
                entries[status.d.tag].decode_stalls <= d_stalls_nxt;
            end
        end
    end

    //////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////

    // asynchronous read at the write-back tag
    assign rd_entry = entries[status.w.tag];

endmodule

// File: src/trace_record_builder.sv
// trace record builder
`timescale 1ns/10ps

module trace_record_builder (
    input  logic                          clk,
    input  logic                          rst,
    input  pipe_trace_pkg::stage_status_t status,
    input  pipe_trace_pkg::table_entry_t  rd_entry,
    output logic                          trace_valid,
    output pipe_trace_pkg::trace_record_t trace
);

    pipe_trace_pkg::instr_word_u   word;
    pipe_trace_pkg::trace_record_t rec;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    always_comb begin
        word = rd_entry.word;

        rec.tag           = status.w.tag;
        rec.fetch_cycle   = rd_entry.fetch_cycle;
        // w is occupied in the current cycle
        rec.retire_cycle  = status.cycle;
        rec.fetch_stalls  = rd_entry.fetch_stalls;
        rec.decode_stalls = rd_entry.decode_stalls;
        rec.word          = word;

        if (word.s_view.opcode == pipe_trace_pkg::OPC_STORE) begin
            // store offset rebuilt from the split immediate
            rec.kind  = pipe_trace_pkg::KIND_STORE;
            rec.field = {word.s_view.imm_hi, word.s_view.imm_lo};
        end else if (word.r_view.opcode == pipe_trace_pkg::OPC_BRANCH ||
                     word.r_view.rd == 5'd0) begin
            // no architectural destination
            rec.kind  = pipe_trace_pkg::KIND_OTHER;
            rec.field = '0;
        end else begin
            rec.kind  = pipe_trace_pkg::KIND_REG;
            rec.field = {7'd0, word.r_view.rd};
        end
    end

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    // one pulse per retiring instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
        end else begin
            trace_valid <= status.w.valid;
        end
    end

    // payload only loads on a retire
    always_ff @(posedge clk) begin
        if (status.w.valid) begin
            trace <= rec;
        end
    end

endmodule

// File: src/pipe_trace_top.sv
// pipe trace top level
`timescale 1ns/10ps

module pipe_trace_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetch_valid,
    input  logic [31:0]                   fetch_word,
    input  logic                          stall,
    input  logic                          flush,
    output logic                          trace_valid,
    output pipe_trace_pkg::trace_record_t trace
);

    pipe_trace_pkg::stage_status_t status;
    pipe_trace_pkg::stage_slot_t   alloc;
    pipe_trace_pkg::table_entry_t  rd_entry;

    //////////////////////////////////////////////////
    // occupancy and tags
    //////////////////////////////////////////////////

    stage_tracker u_stage_tracker (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .flush       (flush),
        .status      (status),
        .alloc       (alloc)
    );

    // per-tag store, runs beside the tracker
    trace_table u_trace_table (
        .clk        (clk),
        .rst        (rst),
        .alloc      (alloc),
        .fetch_word (fetch_word),
        .status     (status),
        .rd_entry   (rd_entry)
    );

    //////////////////////////////////////////////////
    // record out
    //////////////////////////////////////////////////

    trace_record_builder u_trace_record_builder (
        .clk         (clk),
        .rst         (rst),
        .status      (status),
        .rd_entry    (rd_entry),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

endmodule

// File: verification/pipe_trace_sva.sv
// pipeline tracker assertions
`timescale 1ns/10ps

module pipe_trace_sva (
    input logic                          clk,
    input logic                          rst,
    input logic                          stall,
    input logic                          flush,
    input pipe_trace_pkg::stage_status_t status
);

    //////////////////////////////////////////////////
    // occupancy rules
    //////////////////////////////////////////////////

    // nothing in flight on the edge after reset
    a_empty_after_reset: assert property (@(posedge clk)
        $past(rst) |-> !(status.f.valid || status.d.valid || status.e.valid ||
                         status.m.valid || status.w.valid))
        else $error("stage slot valid right after reset");

    // front end frozen while stalled
    a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        (stall && !flush) |=> (status.f == $past(status.f)) && (status.d == $past(status.d)))
        else $error("f or d slot moved during stall");

    // bubble into execute on stall or flush
    a_bubble_in_e: assert property (@(posedge clk) disable iff (rst)
        (stall || flush) |=> !status.e.valid)
        else $error("e slot valid after stall or flush");

    // flush kills fetch and decode
    a_flush_front: assert property (@(posedge clk) disable iff (rst)
        flush |=> !status.f.valid && !status.d.valid)
        else $error("f or d slot valid after flush");

endmodule

// attach to every stage_tracker instance
bind stage_tracker pipe_trace_sva u_pipe_trace_sva (
    .clk    (clk),
    .rst    (rst),
    .stall  (stall),
    .flush  (flush),
    .status (status)
);

// File: verification/pipe_trace_tb.sv
// pipe trace testbench
`timescale 1ns/10ps
`include "pipe_trace_cfg.svh"

module pipe_trace_tb;

    localparam logic [31:0] SEED          = 32'h83a802f9;
    localparam int          RESET_CYCLES  = 10;
    localparam int          RUN_CYCLES    = 2000;
    localparam int          DRAIN_TIMEOUT = 20;

    // one model stage, carries everything a record needs
    typedef struct packed {
        logic                   valid;
        logic [`PT_TAG_W-1:0]   tag;
        logic [31:0]            word;
        logic [`PT_CYCLE_W-1:0] fetch_cycle;
        logic [`PT_STALL_W-1:0] fetch_stalls;
        logic [`PT_STALL_W-1:0] decode_stalls;
    } model_slot_t;

    logic                          clk;
    logic                          rst;
    logic                          fetch_valid;
    logic [31:0]                   fetch_word;
    logic                          stall;
    logic                          flush;
    logic                          trace_valid;
    pipe_trace_pkg::trace_record_t trace;

    // model state
    model_slot_t                   mf, md, me, mm, mw;
    logic [`PT_CYCLE_W-1:0]        m_cycle;
    logic [`PT_TAG_W-1:0]          m_tag;
    pipe_trace_pkg::trace_record_t exp_q[$];

    int          stall_left;
    int          records_seen;
    int          cycle_idx;
    logic        checks_armed;

    pipe_trace_top UUT (
        .clk         (clk),
        .rst         (rst),
        .fetch_valid (fetch_valid),
        .fetch_word  (fetch_word),
        .stall       (stall),
        .flush       (flush),
        .trace_valid (trace_valid),
        .trace       (trace)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // reporting
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic stop_with_error(input string what);
        $display("Error at %0t: %s", $time, what);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    // R, I, store, branch or zero-rd encoding over random upper bits
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        case ($urandom % 5)
            0: w[6:0] = 7'b0110011;
            1: w[6:0] = 7'b0010011;
            2: w[6:0] = 7'b0100011;
            3: w[6:0] = 7'b1100011;
            default: begin
                w[6:0]  = 7'b0010011;
                w[11:7] = 5'd0;
            end
        endcase
        return w;
    endfunction

    task automatic drive_random_inputs();
        fetch_valid <= ($urandom % 100) < 80;
        fetch_word  <= random_word();
        flush       <= ($urandom % 100) < 5;
        // stall comes in runs of 1 to 3 cycles
        if (stall_left != 0) begin
            stall      <= 1'b1;
            stall_left = stall_left - 1;
        end else if (($urandom % 100) < 11) begin
            stall      <= 1'b1;
            stall_left = $urandom % 3;
        end else begin
            stall <= 1'b0;
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // record as the unit should report it when s retires in cycle cyc
    function automatic pipe_trace_pkg::trace_record_t expected_record(
        input model_slot_t s, input logic [`PT_CYCLE_W-1:0] cyc);
        pipe_trace_pkg::trace_record_t rec;
        rec.tag           = s.tag;
        rec.fetch_cycle   = s.fetch_cycle;
        rec.retire_cycle  = cyc;
        rec.fetch_stalls  = s.fetch_stalls;
        rec.decode_stalls = s.decode_stalls;
        rec.word          = s.word;
        if (s.word[6:0] == 7'b0100011) begin
            // store offset is imm[11:5] then imm[4:0]
            rec.kind  = pipe_trace_pkg::KIND_STORE;
            rec.field = {s.word[31:25], s.word[11:7]};
        end else if (s.word[6:0] == 7'b1100011 || s.word[11:7] == 5'd0) begin
            rec.kind  = pipe_trace_pkg::KIND_OTHER;
            rec.field = 12'd0;
        end else begin
            rec.kind  = pipe_trace_pkg::KIND_REG;
            rec.field = {7'd0, s.word[11:7]};
        end
        return rec;
    endfunction

    task automatic update_model();
        model_slot_t fetched;
        if (rst) begin
            mf      = '0;
            md      = '0;
            me      = '0;
            mm      = '0;
            mw      = '0;
            m_cycle = '0;
            m_tag   = '0;
            exp_q.delete();
        end else begin
            // w occupied now, record shows up next cycle
            if (mw.valid) begin
                exp_q.push_back(expected_record(mw, m_cycle));
            end
            // held cycles in f and d, saturating
            if (stall && !flush) begin
                if (mf.valid && !(&mf.fetch_stalls)) begin
                    mf.fetch_stalls = mf.fetch_stalls + 1'b1;
                end
                if (md.valid && !(&md.decode_stalls)) begin
                    md.decode_stalls = md.decode_stalls + 1'b1;
                end
            end
            mw = mm;
            mm = me;
            if (flush) begin
                mf = '0;
                md = '0;
                me = '0;
            end else if (stall) begin
                me = '0;
            end else begin
                me      = md;
                md      = mf;
                fetched = '0;
                if (fetch_valid) begin
                    fetched.valid       = 1'b1;
                    fetched.tag         = m_tag;
                    fetched.word        = fetch_word;
                    // first cycle spent in f
                    fetched.fetch_cycle = m_cycle + 1'b1;
                    m_tag               = m_tag + 1'b1;
                end
                mf = fetched;
            end
            m_cycle = m_cycle + 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // output checks
    //////////////////////////////////////////////////

    // outputs are registered, so at the edge they still show the last cycle
    task automatic check_outputs();
        pipe_trace_pkg::trace_record_t exp_rec;
        logic [`PT_CYCLE_W-1:0]        span;
        check_value("trace_valid", 32'(trace_valid), 32'(exp_q.size() != 0));
        if (trace_valid === 1'b1) begin
            exp_rec = exp_q.pop_front();
            check_value("trace.tag", 32'(trace.tag), 32'(exp_rec.tag));
            check_value("trace.kind", 32'(trace.kind), 32'(exp_rec.kind));
            check_value("trace.field", 32'(trace.field), 32'(exp_rec.field));
            check_value("trace.word", trace.word, exp_rec.word);
            check_value("trace.fetch_cycle", 32'(trace.fetch_cycle),
                        32'(exp_rec.fetch_cycle));
            check_value("trace.retire_cycle", 32'(trace.retire_cycle),
                        32'(exp_rec.retire_cycle));
            check_value("trace.fetch_stalls", 32'(trace.fetch_stalls),
                        32'(exp_rec.fetch_stalls));
            check_value("trace.decode_stalls", 32'(trace.decode_stalls),
                        32'(exp_rec.decode_stalls));
            // pipeline span only holds while neither count saturated
            span = trace.retire_cycle - trace.fetch_cycle;
            if (!(&exp_rec.fetch_stalls) && !(&exp_rec.decode_stalls)) begin
                check_value("retire_cycle - fetch_cycle", 32'(span),
                            32'(4 + exp_rec.fetch_stalls + exp_rec.decode_stalls));
            end
            records_seen++;
        end
    endtask

    always @(posedge clk) begin
        if (checks_armed) begin
            check_outputs();
        end
        update_model();
        checks_armed <= 1'b1;
    end

    function automatic logic pipeline_busy();
        return mf.valid | md.valid | me.valid | mm.valid | mw.valid | (exp_q.size() != 0);
    endfunction

    // model only moves on rising edges, so falling edges see it settled
    task automatic wait_for_drain();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (pipeline_busy() && waited < DRAIN_TIMEOUT);
        if (pipeline_busy()) begin
            stop_with_error("pipeline did not drain within the timeout");
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        fetch_valid  = 1'b0;
        fetch_word   = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        stall_left   = 0;
        records_seen = 0;
        checks_armed = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (cycle_idx = 0; cycle_idx < RUN_CYCLES; cycle_idx++) begin
            @(posedge clk);
            drive_random_inputs();
        end
        // quiet front end, let the last instructions retire
        @(posedge clk);
        fetch_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;
        wait_for_drain();
        if (records_seen == 0) begin
            stop_with_error("no trace record came out during the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// File: files.f
+incdir+include
src/pipe_trace_pkg.sv
src/stage_tracker.sv
src/trace_table.sv
src/trace_record_builder.sv
src/pipe_trace_top.sv
verification/pipe_trace_sva.sv
verification/pipe_trace_tb.sv

// File: Makefile
# Verilator flow for the pipe trace unit

SIM        := verilator
TOP        := pipe_trace_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -Mdir $(OBJ_DIR)
PASS_TEXT  := SIMULATION PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
